//--- rtl/fcvt_pkg.sv
// Shared definitions for the single-precision conversion unit
// Format constants, operation and rounding encodings, saturation values

`default_nettype none

package fcvt_pkg;

  // ----------------------------------------
  // IEEE 754 single-precision format
  // ----------------------------------------

  // Exponent field width
  localparam int EXP_WIDTH = 8;
  // Stored fraction width, hidden bit excluded
  localparam int MAN_WIDTH = 23;
  // Exponent bias
  localparam int EXP_BIAS  = 127;
  // Integer register width, RV32
  localparam int XLEN      = 32;

  // ----------------------------------------
  // Integer saturation values
  // ----------------------------------------

  // Largest signed 32-bit value
  localparam logic [XLEN-1:0] INT_MAX  = 32'h7FFF_FFFF;
  // Smallest signed 32-bit value
  localparam logic [XLEN-1:0] INT_MIN  = 32'h8000_0000;
  // Largest unsigned 32-bit value
  localparam logic [XLEN-1:0] UINT_MAX = 32'hFFFF_FFFF;

  // ----------------------------------------
  // Encodings
  // ----------------------------------------

  // Conversion opcodes
  // Bit 1 set for integer to float, bit 0 set for unsigned integer side
  typedef enum logic [1:0] {
    FCVT_W_S  = 2'b00,
    FCVT_WU_S = 2'b01,
    FCVT_S_W  = 2'b10,
    FCVT_S_WU = 2'b11
  } fcvt_op_t;

  // Rounding modes, codes 5 to 7 act as round toward zero
  typedef enum logic [2:0] {
    RM_RNE = 3'd0,
    RM_RTZ = 3'd1,
    RM_RDN = 3'd2,
    RM_RUP = 3'd3,
    RM_RMM = 3'd4
  } fcvt_rm_t;

  // Sequencer states
  typedef enum logic [1:0] {
    ST_IDLE    = 2'd0,
    ST_CONVERT = 2'd1,
    ST_ROUND   = 2'd2,
    ST_DONE    = 2'd3
  } fcvt_state_t;

endpackage

`default_nettype wire

//--- rtl/fcvt_f2i.sv
// Float to 32-bit integer unit
// Truncates toward zero, saturates out-of-range values, raises nv and nx

`default_nettype none

module fcvt_f2i import fcvt_pkg::*; (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            accept,
  input  fcvt_op_t        operation,
  input  logic [XLEN-1:0] fp_operand,
  output logic [XLEN-1:0] int_result,
  output logic            nv,
  output logic            nx
);

  // Latched operand and opcode
  fcvt_op_t                  op_q;
  logic [XLEN-1:0]           fp_q;
  // Result load strobe, one cycle after accept
  logic                      calc_q;

  // Operand fields
  logic                      sign;
  logic [EXP_WIDTH-1:0]      exp_f;
  logic [MAN_WIDTH-1:0]      man_f;
  logic                      is_nan;
  logic                      is_inf;
  logic                      is_zero;
  logic                      is_unsigned;
  logic signed [9:0]         int_exp;

  // Hidden bit plus fraction, shifted into integer position
  logic [XLEN+MAN_WIDTH:0]   shifted;
  logic [XLEN-1:0]           int_part;
  logic [MAN_WIDTH-1:0]      frac;

  logic [XLEN-1:0]           res_d;
  logic                      nv_d;
  logic                      nx_d;

  // ----------------------------------------
  // Operand capture
  // ----------------------------------------
  always_ff @(posedge clk) begin
    if (accept) begin
      op_q <= operation;
      fp_q <= fp_operand;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      calc_q <= 1'b0;
    end else begin
      calc_q <= accept;
    end
  end

  // Classify
  assign sign        = fp_q[XLEN-1];
  assign exp_f       = fp_q[XLEN-2:MAN_WIDTH];
  assign man_f       = fp_q[MAN_WIDTH-1:0];
  assign is_nan      = (exp_f == '1) && (man_f != '0);
  assign is_inf      = (exp_f == '1) && (man_f == '0);
  // Covers both +0.0 and -0.0
  assign is_zero     = (fp_q[XLEN-2:0] == '0);
  assign is_unsigned = op_q[0];
  // Denormals land at -127 and fall in the below-one case
  assign int_exp     = $signed({2'b00, exp_f}) - 10'sd127;

  // Only meaningful for exponents 0 to 31
  assign shifted  = {{XLEN{1'b0}}, 1'b1, man_f} << int_exp[4:0];
  assign int_part = shifted[XLEN+MAN_WIDTH-1:MAN_WIDTH];
  assign frac     = shifted[MAN_WIDTH-1:0];

  // ----------------------------------------
  // Result and flag selection
  // ----------------------------------------
  always_comb begin
    res_d = '0;
    nv_d  = 1'b0;
    nx_d  = 1'b0;
    if (is_nan) begin
      res_d = is_unsigned ? UINT_MAX : INT_MAX;
      nv_d  = 1'b1;
    end else if (is_inf) begin
      if (is_unsigned) begin
        res_d = sign ? '0 : UINT_MAX;
      end else begin
        res_d = sign ? INT_MIN : INT_MAX;
      end
      nv_d = 1'b1;
    end else if (is_zero) begin
      res_d = '0;
    end else if (int_exp < 0) begin
      // Magnitude below one truncates to zero
      nx_d = 1'b1;
    end else if (is_unsigned) begin
      if (sign || int_exp > 31) begin
        // Negative of magnitude one or more, or too large
        res_d = sign ? '0 : UINT_MAX;
        nv_d  = 1'b1;
      end else begin
        res_d = int_part;
        nx_d  = |frac;
      end
    end else if (int_exp > 31 || (int_exp == 31 && !(sign && man_f == '0))) begin
      // Outside -2^31 .. 2^31-1
      res_d = sign ? INT_MIN : INT_MAX;
      nv_d  = 1'b1;
    end else begin
      // Exactly -2^31 negates to itself
      res_d = sign ? -int_part : int_part;
      nx_d  = |frac;
    end
  end

  // Result registers
  always_ff @(posedge clk) begin
    if (calc_q) begin
      int_result <= res_d;
    end
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      nv <= 1'b0;
      nx <= 1'b0;
    end else if (calc_q) begin
      nv <= nv_d;
      nx <= nx_d;
    end
  end

  // Invalid and inexact exclude each other
  a_flags_excl: assert property (@(posedge clk) disable iff (!reset_n)
    calc_q |=> !(nv && nx));

endmodule

`default_nettype wire

//--- rtl/fcvt_i2f.sv
// Integer to float unit
// Normalizes at accept, rounds under the latched mode on advance

`default_nettype none

module fcvt_i2f import fcvt_pkg::*; (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            accept,
  input  logic            advance,
  input  fcvt_op_t        operation,
  input  fcvt_rm_t        rounding_mode,
  input  logic [XLEN-1:0] int_operand,
  output logic [XLEN-1:0] fp_result,
  output logic            nx
);

  // Stage 1 combinational
  logic                  neg_d;
  logic [XLEN-1:0]       abs_d;
  logic [5:0]            lz_d;
  logic [XLEN-1:0]       norm_d;
  logic [EXP_WIDTH-1:0]  exp_d;

  // Stage 1 registers
  logic                  sign_q;
  logic                  zero_q;
  logic [EXP_WIDTH-1:0]  exp_q;
  logic [MAN_WIDTH-1:0]  man_q;
  logic                  guard_q;
  logic                  round_q;
  logic                  sticky_q;

  // Stage 2 combinational
  logic                  inexact;
  logic                  round_up;
  logic [MAN_WIDTH:0]    man_sum;
  logic [EXP_WIDTH-1:0]  exp_r;

  // Leading zero count, 32 for a zero input
  function automatic logic [5:0] clz32(input logic [XLEN-1:0] v);
    logic [5:0] n;
    logic       found;
    n     = '0;
    found = 1'b0;
    for (int i = XLEN - 1; i >= 0; i--) begin
      if (!found) begin
        if (v[i]) begin
          found = 1'b1;
        end else begin
          n = n + 6'd1;
        end
      end
    end
    return n;
  endfunction

  // ----------------------------------------
  // Stage 1, normalize
  // ----------------------------------------

  // Sign only for the signed opcode
  assign neg_d  = !operation[0] && int_operand[XLEN-1];
  // INT_MIN stays 0x80000000, read as unsigned magnitude
  assign abs_d  = neg_d ? -int_operand : int_operand;
  assign lz_d   = clz32(abs_d);
  // Leading one moved to bit 31
  assign norm_d = abs_d << lz_d;
  assign exp_d  = EXP_WIDTH'(EXP_BIAS + XLEN - 1) - EXP_WIDTH'(lz_d);

  always_ff @(posedge clk) begin
    if (accept) begin
      sign_q   <= neg_d;
      zero_q   <= (abs_d == '0);
      exp_q    <= exp_d;
      // Hidden bit at 31 dropped
      man_q    <= norm_d[XLEN-2 -: MAN_WIDTH];
      guard_q  <= norm_d[XLEN-2-MAN_WIDTH];
      round_q  <= norm_d[XLEN-3-MAN_WIDTH];
      sticky_q <= |norm_d[XLEN-4-MAN_WIDTH:0];
    end
  end

  // ----------------------------------------
  // Stage 2, round
  // ----------------------------------------
  assign inexact = guard_q || round_q || sticky_q;

  always_comb begin
    case (rounding_mode)
      RM_RNE:  round_up = guard_q && (round_q || sticky_q || man_q[0]);
      RM_RTZ:  round_up = 1'b0;
      RM_RDN:  round_up = sign_q && inexact;
      RM_RUP:  round_up = !sign_q && inexact;
      RM_RMM:  round_up = guard_q;
      // Reserved codes truncate
      default: round_up = 1'b0;
    endcase
  end

  // Carry out of the fraction bumps the exponent
  assign man_sum = {1'b0, man_q} + (MAN_WIDTH+1)'(round_up);
  assign exp_r   = exp_q + EXP_WIDTH'(man_sum[MAN_WIDTH]);

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      fp_result <= '0;
      nx        <= 1'b0;
    end else if (advance) begin
      if (zero_q) begin
        // Zero input gives +0.0
        fp_result <= '0;
        nx        <= 1'b0;
      end else begin
        fp_result <= {sign_q, exp_r, man_sum[MAN_WIDTH-1:0]};
        nx        <= inexact;
      end
    end
  end

  // 32-bit magnitudes stay far below the infinity exponent
  a_no_inf: assert property (@(posedge clk) disable iff (!reset_n)
    advance |=> (fp_result[XLEN-2:MAN_WIDTH] != '1));

endmodule

`default_nettype wire

//--- rtl/fcvt_seq.sv
// Conversion sequencer
// Runs the start/busy/done FSM and merges the selected unit's result and flags

`default_nettype none

module fcvt_seq import fcvt_pkg::*; (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            start,
  input  fcvt_op_t        operation,
  input  fcvt_rm_t        rounding_mode,
  input  logic [XLEN-1:0] f2i_result,
  input  logic            f2i_nv,
  input  logic            f2i_nx,
  input  logic [XLEN-1:0] i2f_result,
  input  logic            i2f_nx,
  output logic            accept,
  output logic            advance,
  output fcvt_rm_t        rm_latched,
  output logic            busy,
  output logic            done,
  output logic [XLEN-1:0] int_result,
  output logic [XLEN-1:0] fp_result,
  output logic            flag_nv,
  output logic            flag_nx
);

  fcvt_state_t state;
  fcvt_state_t state_next;
  fcvt_op_t    op_q;

  // ----------------------------------------
  // FSM
  // ----------------------------------------

  // Start outside idle is dropped
  assign accept  = (state == ST_IDLE) && start;
  assign advance = (state == ST_CONVERT);
  assign busy    = (state == ST_CONVERT) || (state == ST_ROUND);
  assign done    = (state == ST_DONE);

  always_comb begin
    case (state)
      ST_IDLE:    state_next = start ? ST_CONVERT : ST_IDLE;
      ST_CONVERT: state_next = ST_ROUND;
      ST_ROUND:   state_next = ST_DONE;
      default:    state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      state      <= ST_IDLE;
      op_q       <= FCVT_W_S;
      rm_latched <= RM_RNE;
    end else begin
      state <= state_next;
      if (accept) begin
        op_q       <= operation;
        rm_latched <= rounding_mode;
      end
    end
  end

  // Output registers, flags start clean on every accept
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      int_result <= '0;
      fp_result  <= '0;
      flag_nv    <= 1'b0;
      flag_nx    <= 1'b0;
    end else if (accept) begin
      flag_nv <= 1'b0;
      flag_nx <= 1'b0;
    end else if (state == ST_ROUND) begin
      if (op_q[1]) begin
        // Integer to float never invalid
        fp_result <= i2f_result;
        flag_nv   <= 1'b0;
        flag_nx   <= i2f_nx;
      end else begin
        int_result <= f2i_result;
        flag_nv    <= f2i_nv;
        flag_nx    <= f2i_nx;
      end
    end
  end

  a_done_pulse: assert property (@(posedge clk) disable iff (!reset_n) done |=> !done);
  a_busy_done: assert property (@(posedge clk) disable iff (!reset_n) !(busy && done));

endmodule

`default_nettype wire

//--- rtl/fp_converter.sv
// RV32 single-precision conversion unit, top level
// Sequencer with the two conversion units side by side

`default_nettype none

module fp_converter import fcvt_pkg::*; (
  input  logic            clk,
  input  logic            reset_n,
  input  logic            start,
  input  fcvt_op_t        operation,
  input  fcvt_rm_t        rounding_mode,
  input  logic [XLEN-1:0] int_operand,
  input  logic [XLEN-1:0] fp_operand,
  output logic            busy,
  output logic            done,
  output logic [XLEN-1:0] int_result,
  output logic [XLEN-1:0] fp_result,
  output logic            flag_nv,
  output logic            flag_nx
);

  // Sequencer controls
  logic            accept;
  logic            advance;
  fcvt_rm_t        rm_latched;

  // Unit results back to the sequencer
  logic [XLEN-1:0] f2i_result;
  logic            f2i_nv;
  logic            f2i_nx;
  logic [XLEN-1:0] i2f_result;
  logic            i2f_nx;

  fcvt_seq i_fcvt_seq (
    .clk           (clk),
    .reset_n       (reset_n),
    .start         (start),
    .operation     (operation),
    .rounding_mode (rounding_mode),
    .f2i_result    (f2i_result),
    .f2i_nv        (f2i_nv),
    .f2i_nx        (f2i_nx),
    .i2f_result    (i2f_result),
    .i2f_nx        (i2f_nx),
    .accept        (accept),
    .advance       (advance),
    .rm_latched    (rm_latched),
    .busy          (busy),
    .done          (done),
    .int_result    (int_result),
    .fp_result     (fp_result),
    .flag_nv       (flag_nv),
    .flag_nx       (flag_nx)
  );

  // Both units start on every accept
  fcvt_f2i i_fcvt_f2i (
    .clk        (clk),
    .reset_n    (reset_n),
    .accept     (accept),
    .operation  (operation),
    .fp_operand (fp_operand),
    .int_result (f2i_result),
    .nv         (f2i_nv),
    .nx         (f2i_nx)
  );

  fcvt_i2f i_fcvt_i2f (
    .clk           (clk),
    .reset_n       (reset_n),
    .accept        (accept),
    .advance       (advance),
    .operation     (operation),
    .rounding_mode (rm_latched),
    .int_operand   (int_operand),
    .fp_result     (i2f_result),
    .nx            (i2f_nx)
  );

endmodule

`default_nettype wire

//--- tb/fcvt_ref_model.svh
// Reference model for the conversion unit testbench
// Expected results and flags worked out from the IEEE and RV32 conversion rules

`ifndef FCVT_REF_MODEL_SVH
`define FCVT_REF_MODEL_SVH

// Float to integer, returns {nv, nx, result}
function automatic logic [33:0] ref_f2i(input fcvt_op_t op, input logic [31:0] f);
  logic        sgn;
  int          e;
  logic [63:0] m;
  logic [63:0] mag;
  logic        inv;
  logic        inexact;
  logic [31:0] r;
  sgn     = f[31];
  e       = int'(f[30:23]) - EXP_BIAS;
  m       = {40'd0, 1'b1, f[22:0]};
  mag     = 64'd0;
  inv     = 1'b0;
  inexact = 1'b0;
  r       = 32'd0;
  if (f[30:23] == 8'hFF) begin
    inv = 1'b1;
    // NaN saturates positive regardless of sign
    if (f[22:0] != 23'd0) r = op[0] ? UINT_MAX : INT_MAX;
    else if (op[0]) r = sgn ? 32'd0 : UINT_MAX;
    else r = sgn ? INT_MIN : INT_MAX;
  end else if (f[30:0] == 31'd0) begin
    r = 32'd0;
  end else if (e < 0) begin
    // Below one, denormals included
    inexact = 1'b1;
  end else if (e > 40) begin
    inv = 1'b1;
    if (op[0]) r = sgn ? 32'd0 : UINT_MAX;
    else r = sgn ? INT_MIN : INT_MAX;
  end else begin
    if (e >= 23) begin
      mag = m << (e - 23);
    end else begin
      mag     = m >> (23 - e);
      inexact = (m & ((64'd1 << (23 - e)) - 64'd1)) != 64'd0;
    end
    if (op[0]) begin
      // Unsigned range 0 to 2^32-1
      if (sgn) begin
        inv = 1'b1;
        r   = 32'd0;
      end else if (mag > 64'hFFFF_FFFF) begin
        inv = 1'b1;
        r   = UINT_MAX;
      end else begin
        r = mag[31:0];
      end
    end else if (!sgn && mag > 64'h7FFF_FFFF) begin
      inv = 1'b1;
      r   = INT_MAX;
    end else if (sgn && mag > 64'h8000_0000) begin
      inv = 1'b1;
      r   = INT_MIN;
    end else begin
      r = sgn ? -mag[31:0] : mag[31:0];
    end
    if (inv) inexact = 1'b0;
  end
  return {inv, inexact, r};
endfunction

// Integer to float, returns {nx, result}
function automatic logic [32:0] ref_i2f(input fcvt_op_t op, input fcvt_rm_t rm,
                                        input logic [31:0] x);
  logic        neg;
  logic [63:0] mag;
  logic [63:0] kept;
  logic [63:0] rem;
  logic [63:0] half;
  int          p;
  int          sh;
  logic        up;
  logic [7:0]  ex;
  neg  = !op[0] && x[31];
  mag  = neg ? {32'd0, -x} : {32'd0, x};
  rem  = 64'd0;
  half = 64'd0;
  up   = 1'b0;
  p    = 0;
  if (mag == 64'd0) return 33'd0;
  for (int i = 0; i < 32; i++) begin
    if (mag[i]) p = i;
  end
  if (p <= 23) begin
    kept = mag << (23 - p);
  end else begin
    // Dropped bits weighed against half an ulp
    sh   = p - 23;
    kept = mag >> sh;
    rem  = mag & ((64'd1 << sh) - 64'd1);
    half = 64'd1 << (sh - 1);
    case (rm)
      RM_RNE:  up = (rem > half) || (rem == half && kept[0]);
      RM_RDN:  up = neg && rem != 64'd0;
      RM_RUP:  up = !neg && rem != 64'd0;
      RM_RMM:  up = rem >= half;
      default: up = 1'b0;
    endcase
  end
  kept = kept + 64'(up);
  ex   = 8'(EXP_BIAS + p);
  // Rounded past 2^24, renormalize
  if (kept[24]) begin
    kept = kept >> 1;
    ex   = ex + 8'd1;
  end
  return {rem != 64'd0, neg, ex, kept[22:0]};
endfunction

`endif

//--- tb/tb_fp_converter.sv
// Testbench for the single-precision conversion unit
// Handshake timing, float/integer conversions, saturation, rounding, flag clearing

`default_nettype none

module tb_fp_converter import fcvt_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  `include "fcvt_ref_model.svh"

  localparam int DONE_TIMEOUT = 16;

  logic            clk = 1'b0;
  logic            reset_n;
  logic            start;
  fcvt_op_t        operation;
  fcvt_rm_t        rounding_mode;
  logic [31:0]     int_operand;
  logic [31:0]     fp_operand;
  logic            busy;
  logic            done;
  logic [31:0]     int_result;
  logic [31:0]     fp_result;
  logic            flag_nv;
  logic            flag_nx;

  // Bookkeeping
  logic [31:0]     lfsr_state;
  string           cur_test;
  int              tests;
  int              checks;
  int              errors;
  int              checks_at_start;
  int              errors_at_start;

  fp_converter i_fp_converter (
    .clk           (clk),
    .reset_n       (reset_n),
    .start         (start),
    .operation     (operation),
    .rounding_mode (rounding_mode),
    .int_operand   (int_operand),
    .fp_operand    (fp_operand),
    .busy          (busy),
    .done          (done),
    .int_result    (int_result),
    .fp_result     (fp_result),
    .flag_nv       (flag_nv),
    .flag_nx       (flag_nx)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  // Galois LFSR with taps x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = 32'd0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  task automatic begin_test(input string name);
    cur_test        = name;
    checks_at_start = checks;
    errors_at_start = errors;
  endtask

  task automatic end_test();
    tests++;
    $display("%-14s %0d checks, %0d errors", cur_test, checks - checks_at_start,
             errors - errors_at_start);
  endtask

  task automatic check_val(input string what, input logic [31:0] expected,
                           input logic [31:0] actual);
    checks++;
    assert (actual === expected)
    else begin
      errors++;
      $display("ERROR %s %s: expected %h, actual %h", cur_test, what, expected, actual);
    end
  endtask

  // Inputs change 10 ns after the edge and are accepted on the next one
  task automatic start_op(input fcvt_op_t op, input fcvt_rm_t rm, input logic [31:0] opnd);
    @(posedge clk);
    #10;
    operation     = op;
    rounding_mode = rm;
    int_operand   = opnd;
    fp_operand    = opnd;
    start         = 1'b1;
    @(posedge clk);
    #10;
    start = 1'b0;
  endtask

  // Counts edges since accept by sampling on the falling edge
  task automatic wait_done(output int latency, output int busy_cycles, output logic seen);
    latency     = 0;
    busy_cycles = 0;
    seen        = 1'b0;
    while (!seen && latency < DONE_TIMEOUT) begin
      @(negedge clk);
      latency++;
      if (busy) busy_cycles++;
      if (done) seen = 1'b1;
    end
    if (!seen) begin
      errors++;
      $display("%s: done never came within %0d cycles of start", cur_test, DONE_TIMEOUT);
    end
  endtask

  task automatic check_result(input fcvt_op_t op, input fcvt_rm_t rm, input logic [31:0] opnd);
    logic [33:0] ef;
    logic [32:0] ei;
    if (op[1]) begin
      ei = ref_i2f(op, rm, opnd);
      check_val("fp_result", ei[31:0], fp_result);
      check_val("flag_nv", 32'd0, {31'd0, flag_nv});
      check_val("flag_nx", {31'd0, ei[32]}, {31'd0, flag_nx});
    end else begin
      ef = ref_f2i(op, opnd);
      check_val("int_result", ef[31:0], int_result);
      check_val("flag_nv", {31'd0, ef[33]}, {31'd0, flag_nv});
      check_val("flag_nx", {31'd0, ef[32]}, {31'd0, flag_nx});
    end
  endtask

  // Full operation with handshake timing checks
  task automatic run_case(input fcvt_op_t op, input fcvt_rm_t rm, input logic [31:0] opnd);
    int   lat;
    int   bc;
    logic seen;
    start_op(op, rm, opnd);
    wait_done(lat, bc, seen);
    if (seen) begin
      check_val("done latency", 32'd3, 32'(lat));
      check_val("busy cycles", 32'd2, 32'(bc));
      check_result(op, rm, opnd);
    end
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------

  task automatic test_reset_timing();
    int   lat;
    int   bc;
    logic seen;
    begin_test("reset_timing");
    @(negedge clk);
    check_val("busy", 32'd0, {31'd0, busy});
    check_val("done", 32'd0, {31'd0, done});
    check_val("flags", 32'd0, {30'd0, flag_nv, flag_nx});
    check_val("int_result", 32'd0, int_result);
    check_val("fp_result", 32'd0, fp_result);
    run_case(FCVT_W_S, RM_RNE, 32'h4120_0000);
    @(negedge clk);
    check_val("done drop", 32'd0, {31'd0, done});
    // Second start lands while busy
    start_op(FCVT_S_W, RM_RNE, 32'd7);
    operation   = FCVT_W_S;
    int_operand = 32'd99;
    start       = 1'b1;
    @(posedge clk);
    #10;
    start = 1'b0;
    wait_done(lat, bc, seen);
    if (seen) check_result(FCVT_S_W, RM_RNE, 32'd7);
    repeat (3) begin
      @(negedge clk);
      check_val("no second done", 32'd0, {30'd0, done, busy});
    end
    end_test();
  endtask

  task automatic test_f2i();
    logic [31:0] s;
    logic [31:0] eo;
    logic [31:0] mn;
    begin_test("f2i");
    for (int n = 0; n < 24; n++) begin
      rand_bits(1, s);
      rand_bits(6, eo);
      rand_bits(23, mn);
      // Exponents 100 to 163 span below one through overflow
      run_case(n[0] ? FCVT_WU_S : FCVT_W_S, RM_RNE, {s[0], 8'd100 + eo[7:0], mn[22:0]});
    end
    run_case(FCVT_W_S, RM_RNE, 32'h3FC0_0000);
    run_case(FCVT_W_S, RM_RNE, 32'hBFC0_0000);
    run_case(FCVT_WU_S, RM_RNE, 32'h3FC0_0000);
    run_case(FCVT_W_S, RM_RNE, 32'h3F40_0000);
    run_case(FCVT_WU_S, RM_RNE, 32'h8000_0000);
    end_test();
  endtask

  task automatic test_saturation();
    logic [31:0] vals [7];
    vals = '{32'h7FC0_0000, 32'h7F80_0000, 32'hFF80_0000, 32'h4F00_0000,
             32'hCF00_0000, 32'h4F80_0000, 32'hC040_0000};
    begin_test("saturation");
    foreach (vals[k]) begin
      run_case(FCVT_W_S, RM_RNE, vals[k]);
      run_case(FCVT_WU_S, RM_RNE, vals[k]);
    end
    end_test();
  endtask

  task automatic test_i2f();
    logic [31:0] w;
    logic [31:0] sh;
    fcvt_rm_t    rm;
    begin_test("i2f");
    for (int k = 0; k < 5; k++) begin
      rm = fcvt_rm_t'(3'(k));
      for (int n = 0; n < 12; n++) begin
        rand_bits(32, w);
        rand_bits(5, sh);
        run_case(n[0] ? FCVT_S_WU : FCVT_S_W, rm, w >> sh[4:0]);
      end
      run_case(FCVT_S_W, rm, 32'd0);
      run_case(FCVT_S_W, rm, INT_MIN);
      run_case(FCVT_S_WU, rm, INT_MIN);
      run_case(FCVT_S_W, rm, UINT_MAX);
      run_case(FCVT_S_WU, rm, UINT_MAX);
    end
    end_test();
  endtask

  task automatic test_round_carry();
    begin_test("round_carry");
    // 2^25 - 1 rounds up into the next binade
    run_case(FCVT_S_WU, RM_RNE, 32'h01FF_FFFF);
    check_val("rne carry", 32'h4C00_0000, fp_result);
    run_case(FCVT_S_WU, RM_RUP, 32'h01FF_FFFF);
    check_val("rup carry", 32'h4C00_0000, fp_result);
    run_case(FCVT_S_WU, RM_RTZ, 32'h01FF_FFFF);
    check_val("rtz truncate", 32'h4BFF_FFFF, fp_result);
    end_test();
  endtask

  task automatic test_flag_clear();
    begin_test("flag_clear");
    run_case(FCVT_S_W, RM_RTZ, 32'h01FF_FFFF);
    check_val("nx set", 32'd1, {31'd0, flag_nx});
    run_case(FCVT_S_W, RM_RTZ, 32'd5);
    check_val("nx cleared", 32'd0, {31'd0, flag_nx});
    run_case(FCVT_W_S, RM_RNE, 32'h3FC0_0000);
    check_val("nx set", 32'd1, {31'd0, flag_nx});
    run_case(FCVT_W_S, RM_RNE, 32'h4000_0000);
    check_val("nx cleared", 32'd0, {31'd0, flag_nx});
    end_test();
  endtask

  // ----------------------------------------
  // Main sequence
  // ----------------------------------------
  initial begin
    reset_n       = 1'b0;
    start         = 1'b0;
    operation     = FCVT_W_S;
    rounding_mode = RM_RNE;
    int_operand   = 32'd0;
    fp_operand    = 32'd0;
    lfsr_state    = 32'h7bf1;
    tests         = 0;
    checks        = 0;
    errors        = 0;
    repeat (8) @(posedge clk);
    #10;
    reset_n = 1'b1;
    test_reset_timing();
    test_f2i();
    test_saturation();
    test_i2f();
    test_round_carry();
    test_flag_clear();
    $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
+incdir+tb
rtl/fcvt_pkg.sv
rtl/fcvt_f2i.sv
rtl/fcvt_i2f.sv
rtl/fcvt_seq.sv
rtl/fp_converter.sv
tb/tb_fp_converter.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the conversion unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
  -f sources.f --top-module tb_fp_converter -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vtb_fp_converter > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "Regression passed" "$LOG"; then
  exit 0
fi
echo "No pass line found in $LOG"
exit 1
